/* rtl/chdr_pkg.sv */
/*
 * CHDR bus definitions for the 64-bit deframer.
 * Holds the header field layout, the packet-type encoding and the
 * raw beat struct used on the input and on the payload path.
 */

package chdr_pkg;

  // --------------------
  // Bus width and word
  // --------------------
  localparam int CHDR_W = 64;

  typedef logic [CHDR_W-1:0] chdr_word_t;

  // Packet type, header bits [55:53]
  typedef enum logic [2:0] {
    MGMT    = 3'd0,
    STRS    = 3'd1,
    STRC    = 3'd2,
    CTRL    = 3'd4,
    DATA    = 3'd6,
    DATA_TS = 3'd7
  } chdr_pkt_type_e;

  // --------------------
  // Header field layout
  // --------------------
  localparam int PKT_TYPE_LSB  = 53;
  localparam int PKT_TYPE_W    = 3;
  localparam int NUM_MDATA_LSB = 48;
  localparam int NUM_MDATA_W   = 5;

  typedef logic [NUM_MDATA_W-1:0] num_mdata_t;

  // One bus beat: word plus end-of-packet flag
  typedef struct packed {
    chdr_word_t data;
    logic       last;
  } chdr_beat_t;

  // Field extraction from a header word
  function automatic chdr_pkt_type_e get_pkt_type(chdr_word_t hdr);
    return chdr_pkt_type_e'(hdr[PKT_TYPE_LSB +: PKT_TYPE_W]);
  endfunction

  function automatic num_mdata_t get_num_mdata(chdr_word_t hdr);
    return hdr[NUM_MDATA_LSB +: NUM_MDATA_W];
  endfunction

endpackage

/* rtl/ctxt_pkg.sv */
/*
 * Context stream definitions.
 * Each context beat carries a CHDR word tagged with the field it came
 * from: header, timestamp or one of the metadata words.
 */

package ctxt_pkg;

  import chdr_pkg::*;

  // --------------------
  // Context field tag
  // --------------------
  // Code 1 is left free, it marks a combined header and timestamp
  // on buses wider than 64 bits
  typedef enum logic [3:0] {
    HDR   = 4'd0,
    TS    = 4'd2,
    MDATA = 4'd3
  } ctxt_field_e;

  // --------------------
  // Context beat
  // --------------------
  // Word, field tag and last flag, 69 bits in all
  typedef struct packed {
    chdr_word_t  data;
    ctxt_field_e field;
    logic        last;
  } ctxt_beat_t;

endpackage

/* rtl/chdr_header_parser.sv */
/*
 * Input FSM of the deframer.
 * Walks each CHDR packet and steers header, timestamp and metadata
 * words to the context path and body words to the payload path.
 * Non-data packets are swallowed. Purely combinational on the data path.
 */

`timescale 1ns/1ps

module chdr_header_parser (
  input  logic                 axis_chdr_clk,
  input  logic                 axis_chdr_rst,
  // CHDR input
  input  chdr_pkg::chdr_beat_t i_chdr,
  input  logic                 i_chdr_valid,
  output logic                 o_chdr_ready,
  // Context path
  output ctxt_pkg::ctxt_beat_t o_ctxt,
  output logic                 o_ctxt_valid,
  input  logic                 i_ctxt_ready,
  // Payload path
  output chdr_pkg::chdr_beat_t o_pyld,
  output logic                 o_pyld_valid,
  input  logic                 i_pyld_ready
);

  import chdr_pkg::*;
  import ctxt_pkg::*;

  // --------------------
  // State
  // --------------------
  typedef enum logic [2:0] {
    ST_HDR,
    ST_TS,
    ST_MDATA,
    ST_BODY,
    ST_DROP
  } state_e;

  state_e     state;
  num_mdata_t mdata_pending;

  // Header fields, only meaningful in ST_HDR
  chdr_pkt_type_e in_type;
  num_mdata_t     in_num_mdata;
  logic           hdr_is_data;
  logic           accept;

  assign in_type      = get_pkt_type(i_chdr.data);
  assign in_num_mdata = get_num_mdata(i_chdr.data);
  assign hdr_is_data  = (in_type == DATA) || (in_type == DATA_TS);
  assign accept       = i_chdr_valid && o_chdr_ready;

  // --------------------
  // Next state
  // --------------------
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      state         <= ST_HDR;
      mdata_pending <= '0;
    end else if (accept) begin
      case (state)
        ST_HDR: begin
          // Metadata count is cached for every packet
          mdata_pending <= in_num_mdata;
          if (i_chdr.last) begin
            // Header-only packet, resync on next word
            state <= ST_HDR;
          end else if (in_type == DATA_TS) begin
            state <= ST_TS;
          end else if (in_type == DATA) begin
            state <= (in_num_mdata != '0) ? ST_MDATA : ST_BODY;
          end else begin
            state <= ST_DROP;
          end
        end
        ST_TS: begin
          if (i_chdr.last) begin
            state <= ST_HDR;
          end else begin
            state <= (mdata_pending != '0) ? ST_MDATA : ST_BODY;
          end
        end
        ST_MDATA: begin
          // Count down, leave after the final metadata word
          mdata_pending <= mdata_pending - 1'b1;
          if (i_chdr.last) begin
            state <= ST_HDR;
          end else if (mdata_pending == num_mdata_t'(1)) begin
            state <= ST_BODY;
          end
        end
        ST_BODY, ST_DROP: begin
          if (i_chdr.last) begin
            state <= ST_HDR;
          end
        end
        default: begin
          state <= ST_HDR;
        end
      endcase
    end
  end

  // --------------------
  // Beat routing
  // --------------------
  always_comb begin
    // Both paths see the input word, valid selects the one that takes it
    o_ctxt.data  = i_chdr.data;
    o_ctxt.field = HDR;
    o_ctxt.last  = i_chdr.last;
    o_ctxt_valid = 1'b0;
    o_pyld       = i_chdr;
    o_pyld_valid = 1'b0;
    o_chdr_ready = 1'b0;
    case (state)
      ST_HDR: begin
        if (hdr_is_data) begin
          o_ctxt_valid = i_chdr_valid;
          o_chdr_ready = i_ctxt_ready;
          // Plain DATA with no metadata has a one-word context
          o_ctxt.last  = i_chdr.last || ((in_type == DATA) && (in_num_mdata == '0));
        end else begin
          // Dropped types never reach the context FIFO
          o_chdr_ready = 1'b1;
        end
      end
      ST_TS: begin
        o_ctxt.field = TS;
        o_ctxt_valid = i_chdr_valid;
        o_chdr_ready = i_ctxt_ready;
        o_ctxt.last  = i_chdr.last || (mdata_pending == '0);
      end
      ST_MDATA: begin
        o_ctxt.field = MDATA;
        o_ctxt_valid = i_chdr_valid;
        o_chdr_ready = i_ctxt_ready;
        o_ctxt.last  = i_chdr.last || (mdata_pending == num_mdata_t'(1));
      end
      ST_BODY: begin
        // Input last doubles as payload last
        o_pyld_valid = i_chdr_valid;
        o_chdr_ready = i_pyld_ready;
      end
      ST_DROP: begin
        o_chdr_ready = 1'b1;
      end
      default: begin
        o_chdr_ready = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/stream_fifo.sv */
/*
 * Small synchronous valid/ready FIFO, generic over the beat type.
 * A write shows on the read side one cycle later. Ready drops when full.
 */

`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DEPTH  = 2,
  parameter type         beat_t = logic [7:0]
) (
  input  logic  axis_chdr_clk,
  input  logic  axis_chdr_rst,
  // Write side
  input  beat_t i_beat,
  input  logic  i_valid,
  output logic  o_ready,
  // Read side
  output beat_t o_beat,
  output logic  o_valid,
  input  logic  i_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // --------------------
  // Storage and pointers
  // --------------------
  beat_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign o_ready = (count != CNT_W'(DEPTH));
  assign o_valid = (count != '0);
  assign o_beat  = mem[rd_ptr];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Data array, written only
  always_ff @(posedge axis_chdr_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_beat;
    end
  end

  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Occupancy holds on a simultaneous push and pop
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* rtl/packet_order_gate.sv */
/*
 * Output ordering gate.
 * Holds payload back until its context packet has left, and limits
 * how far the context stream may run ahead of the payload.
 */

`timescale 1ns/1ps

module packet_order_gate #(
  parameter bit PREFETCH_EN = 1'b1
) (
  input  logic                 axis_chdr_clk,
  input  logic                 axis_chdr_rst,
  // Context from its FIFO, and out
  input  ctxt_pkg::ctxt_beat_t i_ctxt,
  input  logic                 i_ctxt_valid,
  output logic                 o_ctxt_ready,
  output ctxt_pkg::ctxt_beat_t o_ctxt,
  output logic                 o_ctxt_valid,
  input  logic                 i_ctxt_ready,
  // Payload from its FIFO, and out
  input  chdr_pkg::chdr_beat_t i_pyld,
  input  logic                 i_pyld_valid,
  output logic                 o_pyld_ready,
  output chdr_pkg::chdr_beat_t o_pyld,
  output logic                 o_pyld_valid,
  input  logic                 i_pyld_ready
);

  // Context packets allowed out ahead of their payload
  localparam logic [2:0] CTXT_AHEAD_MAX = PREFETCH_EN ? 3'd2 : 3'd1;

  // --------------------
  // Packet counters
  // --------------------
  logic [2:0] ctxt_pkt_cnt;
  logic [2:0] pyld_pkt_cnt;
  logic [2:0] pkt_diff;
  logic       pass_ctxt;
  logic       pass_pyld;

  // Modulo-8 difference, never exceeds CTXT_AHEAD_MAX
  assign pkt_diff  = ctxt_pkt_cnt - pyld_pkt_cnt;
  assign pass_pyld = (pkt_diff != 3'd0);
  assign pass_ctxt = (pkt_diff < CTXT_AHEAD_MAX);

  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      ctxt_pkt_cnt <= 3'd0;
      pyld_pkt_cnt <= 3'd0;
    end else begin
      // Count at the last beat leaving each output
      if (o_ctxt_valid && i_ctxt_ready && i_ctxt.last) begin
        ctxt_pkt_cnt <= ctxt_pkt_cnt + 3'd1;
      end
      if (o_pyld_valid && i_pyld_ready && i_pyld.last) begin
        pyld_pkt_cnt <= pyld_pkt_cnt + 3'd1;
      end
    end
  end

  // --------------------
  // Handshake gating
  // --------------------
  assign o_ctxt       = i_ctxt;
  assign o_ctxt_valid = i_ctxt_valid && pass_ctxt;
  assign o_ctxt_ready = i_ctxt_ready && pass_ctxt;

  assign o_pyld       = i_pyld;
  assign o_pyld_valid = i_pyld_valid && pass_pyld;
  assign o_pyld_ready = i_pyld_ready && pass_pyld;

endmodule

/* rtl/chdr_deframer.sv */
/*
 * CHDR data-packet deframer, top level.
 * Splits a 64-bit CHDR stream into a tagged context stream and a
 * payload stream, with context always ahead of its payload.
 */

`timescale 1ns/1ps

module chdr_deframer #(
  parameter int unsigned CTXT_FIFO_DEPTH = 2,
  parameter int unsigned PYLD_FIFO_DEPTH = 4,
  parameter bit          PREFETCH_EN     = 1'b1
) (
  input  logic                 axis_chdr_clk,
  input  logic                 axis_chdr_rst,
  // CHDR input
  input  chdr_pkg::chdr_beat_t i_chdr,
  input  logic                 i_chdr_valid,
  output logic                 o_chdr_ready,
  // Context output
  output ctxt_pkg::ctxt_beat_t o_ctxt,
  output logic                 o_ctxt_valid,
  input  logic                 i_ctxt_ready,
  // Payload output
  output chdr_pkg::chdr_beat_t o_pyld,
  output logic                 o_pyld_valid,
  input  logic                 i_pyld_ready
);

  import chdr_pkg::*;
  import ctxt_pkg::*;

  // --------------------
  // Parser to FIFOs
  // --------------------
  ctxt_beat_t in_ctxt;
  logic       in_ctxt_valid;
  logic       in_ctxt_ready;
  chdr_beat_t in_pyld;
  logic       in_pyld_valid;
  logic       in_pyld_ready;

  // FIFOs to gate
  ctxt_beat_t q_ctxt;
  logic       q_ctxt_valid;
  logic       q_ctxt_ready;
  chdr_beat_t q_pyld;
  logic       q_pyld_valid;
  logic       q_pyld_ready;

  chdr_header_parser u_parser (
    .axis_chdr_clk (axis_chdr_clk),
    .axis_chdr_rst (axis_chdr_rst),
    .i_chdr        (i_chdr),
    .i_chdr_valid  (i_chdr_valid),
    .o_chdr_ready  (o_chdr_ready),
    .o_ctxt        (in_ctxt),
    .o_ctxt_valid  (in_ctxt_valid),
    .i_ctxt_ready  (in_ctxt_ready),
    .o_pyld        (in_pyld),
    .o_pyld_valid  (in_pyld_valid),
    .i_pyld_ready  (in_pyld_ready)
  );

  // --------------------
  // Path buffers
  // --------------------
  stream_fifo #(
    .DEPTH  (CTXT_FIFO_DEPTH),
    .beat_t (ctxt_beat_t)
  ) u_ctxt_fifo (
    .axis_chdr_clk (axis_chdr_clk),
    .axis_chdr_rst (axis_chdr_rst),
    .i_beat        (in_ctxt),
    .i_valid       (in_ctxt_valid),
    .o_ready       (in_ctxt_ready),
    .o_beat        (q_ctxt),
    .o_valid       (q_ctxt_valid),
    .i_ready       (q_ctxt_ready)
  );

  stream_fifo #(
    .DEPTH  (PYLD_FIFO_DEPTH),
    .beat_t (chdr_beat_t)
  ) u_pyld_fifo (
    .axis_chdr_clk (axis_chdr_clk),
    .axis_chdr_rst (axis_chdr_rst),
    .i_beat        (in_pyld),
    .i_valid       (in_pyld_valid),
    .o_ready       (in_pyld_ready),
    .o_beat        (q_pyld),
    .o_valid       (q_pyld_valid),
    .i_ready       (q_pyld_ready)
  );

  // Context before payload, optional one-packet prefetch
  packet_order_gate #(
    .PREFETCH_EN (PREFETCH_EN)
  ) u_gate (
    .axis_chdr_clk (axis_chdr_clk),
    .axis_chdr_rst (axis_chdr_rst),
    .i_ctxt        (q_ctxt),
    .i_ctxt_valid  (q_ctxt_valid),
    .o_ctxt_ready  (q_ctxt_ready),
    .o_ctxt        (o_ctxt),
    .o_ctxt_valid  (o_ctxt_valid),
    .i_ctxt_ready  (i_ctxt_ready),
    .i_pyld        (q_pyld),
    .i_pyld_valid  (q_pyld_valid),
    .o_pyld_ready  (q_pyld_ready),
    .o_pyld        (o_pyld),
    .o_pyld_valid  (o_pyld_valid),
    .i_pyld_ready  (i_pyld_ready)
  );

endmodule

/* sim/chdr_deframer_assertions.sv */
/*
 * Input contract checks for the deframer, bound into the header parser.
 * Flags unstable input beats under back-pressure and packets that end
 * before their first payload word.
 */

`timescale 1ns/1ps

module chdr_deframer_assertions (
  input logic                 axis_chdr_clk,
  input logic                 axis_chdr_rst,
  input chdr_pkg::chdr_beat_t i_chdr,
  input logic                 i_chdr_valid,
  input logic                 o_chdr_ready,
  input logic [2:0]           state
);

  // Parser state codes in declaration order
  localparam logic [2:0] S_HDR   = 3'd0;
  localparam logic [2:0] S_TS    = 3'd1;
  localparam logic [2:0] S_MDATA = 3'd2;

  logic in_ctxt_state;

  // Number of contract violations seen so far
  int unsigned fail_count = 0;

  assign in_ctxt_state = (state == S_HDR) || (state == S_TS) || (state == S_MDATA);

  // --------------------
  // Stream contract
  // --------------------
  // Stalled beat must stay put until taken
  assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (i_chdr_valid && !o_chdr_ready) |=> (i_chdr_valid && $stable(i_chdr)))
    else begin
      $error("input beat changed while stalled");
      fail_count++;
    end

  // A packet must reach its body before it ends
  assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (i_chdr_valid && o_chdr_ready && i_chdr.last) |-> !in_ctxt_state)
    else begin
      $error("packet ended before its first payload word");
      fail_count++;
    end

endmodule

bind chdr_header_parser chdr_deframer_assertions u_input_checks (
  .axis_chdr_clk (axis_chdr_clk),
  .axis_chdr_rst (axis_chdr_rst),
  .i_chdr        (i_chdr),
  .i_chdr_valid  (i_chdr_valid),
  .o_chdr_ready  (o_chdr_ready),
  .state         (state)
);

/* sim/tb_chdr_deframer.sv */
/*
 * Directed testbench for the CHDR deframer.
 * Queues packets, builds the expected context and payload beats from
 * the CHDR field rules, and checks both outputs as they leave the DUT.
 */

`timescale 1ns/1ps

module tb_chdr_deframer;

  import chdr_pkg::*;
  import ctxt_pkg::*;

  // Ready modes for the output sinks
  localparam logic [1:0] RDY_LOW  = 2'd0;
  localparam logic [1:0] RDY_HIGH = 2'd1;
  localparam logic [1:0] RDY_RAND = 2'd2;

  logic       axis_chdr_clk = 1'b0;
  logic       axis_chdr_rst;
  chdr_beat_t i_chdr;
  logic       i_chdr_valid;
  logic       o_chdr_ready;
  ctxt_beat_t o_ctxt;
  logic       o_ctxt_valid;
  logic       i_ctxt_ready;
  chdr_beat_t o_pyld;
  logic       o_pyld_valid;
  logic       i_pyld_ready;

  chdr_beat_t tx_q[$];
  ctxt_beat_t exp_ctxt[$];
  chdr_beat_t exp_pyld[$];

  logic [31:0] lfsr = 32'hab96ce52;
  logic [1:0]  ctxt_mode = RDY_HIGH;
  logic [1:0]  pyld_mode = RDY_HIGH;
  logic        sender_done;
  int          ctxt_pkts = 0;
  int          pyld_pkts = 0;
  int          planned_beats = 0;
  int          cycle_cnt = 0;
  int          n_errors = 0;

  chdr_deframer #(
    .CTXT_FIFO_DEPTH (2),
    .PYLD_FIFO_DEPTH (4),
    .PREFETCH_EN     (1'b1)
  ) uut (
    .axis_chdr_clk (axis_chdr_clk),
    .axis_chdr_rst (axis_chdr_rst),
    .i_chdr        (i_chdr),
    .i_chdr_valid  (i_chdr_valid),
    .o_chdr_ready  (o_chdr_ready),
    .o_ctxt        (o_ctxt),
    .o_ctxt_valid  (o_ctxt_valid),
    .i_ctxt_ready  (i_ctxt_ready),
    .o_pyld        (o_pyld),
    .o_pyld_valid  (o_pyld_valid),
    .i_pyld_ready  (i_pyld_ready)
  );

  always #4 axis_chdr_clk = ~axis_chdr_clk;

  // --------------------
  // Helpers
  // --------------------
  task automatic abort_run();
    n_errors++;
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic chdr_word_t make_word(int id, logic [7:0] kind, int idx);
    return {kind, 8'(id), 16'(idx), 32'h6b3d_0000 | 32'(idx * 37 + id)};
  endfunction

  task automatic check_ctxt(input ctxt_beat_t got, input ctxt_beat_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: context got %h/%0d/%b, expected %h/%0d/%b", $time,
               got.data, got.field, got.last, exp.data, exp.field, exp.last);
      abort_run();
    end
  endtask

  task automatic check_pyld(input chdr_beat_t got, input chdr_beat_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: payload got %h/%b, expected %h/%b", $time,
               got.data, got.last, exp.data, exp.last);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Queue one packet and its expected output beats
  task automatic add_packet(input chdr_pkt_type_e t, input int nm, input int nbody,
                            input int id);
    chdr_word_t w;
    chdr_beat_t pb;
    logic       is_data;
    int         nwords;
    is_data = (t == DATA) || (t == DATA_TS);
    nwords  = 1 + ((t == DATA_TS) ? 1 : 0) + nm + nbody;
    w = '0;
    w[63:56] = 8'(id);
    w[PKT_TYPE_LSB +: PKT_TYPE_W] = t;
    w[NUM_MDATA_LSB +: NUM_MDATA_W] = NUM_MDATA_W'(nm);
    w[15:0] = 16'(8 * nwords);
    tx_q.push_back('{data: w, last: 1'b0});
    // Header is the whole context only for plain DATA without metadata
    if (is_data) begin
      exp_ctxt.push_back('{data: w, field: HDR, last: (t == DATA) && (nm == 0)});
    end
    if (t == DATA_TS) begin
      w = make_word(id, 8'h75, 0);
      tx_q.push_back('{data: w, last: 1'b0});
      exp_ctxt.push_back('{data: w, field: TS, last: (nm == 0)});
    end
    for (int i = 0; i < nm; i++) begin
      w = make_word(id, 8'hd0, i);
      tx_q.push_back('{data: w, last: 1'b0});
      exp_ctxt.push_back('{data: w, field: MDATA, last: (i == nm - 1)});
    end
    // Body words pass through unchanged
    for (int i = 0; i < nbody; i++) begin
      pb = '{data: make_word(id, 8'hb0, i), last: (i == nbody - 1)};
      tx_q.push_back(pb);
      if (is_data) begin
        exp_pyld.push_back(pb);
      end
    end
    planned_beats += nwords;
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic drive_word(input chdr_beat_t b);
    logic taken;
    i_chdr       = b;
    i_chdr_valid = 1'b1;
    taken        = 1'b0;
    while (!taken) begin
      @(negedge axis_chdr_clk);
      taken = o_chdr_ready;
      @(posedge axis_chdr_clk);
      #1;
    end
  endtask

  task automatic send_queued();
    chdr_beat_t b;
    while (tx_q.size() != 0) begin
      b = tx_q.pop_front();
      drive_word(b);
    end
    i_chdr_valid = 1'b0;
  endtask

  // Mode changes at the falling edge and takes effect after the next rise
  task automatic set_ready_mode(input logic [1:0] c, input logic [1:0] p);
    @(negedge axis_chdr_clk);
    ctxt_mode = c;
    pyld_mode = p;
    @(posedge axis_chdr_clk);
    #1;
  endtask

  task automatic wait_drained();
    do begin
      @(posedge axis_chdr_clk);
    end while (exp_ctxt.size() != 0 || exp_pyld.size() != 0);
    #1;
  endtask

  // --------------------
  // Sinks and monitors
  // --------------------
  always @(posedge axis_chdr_clk) begin
    logic [31:0] v;
    #1;
    if (ctxt_mode == RDY_RAND) begin
      take_bits(1, v);
      i_ctxt_ready = v[0];
    end else begin
      i_ctxt_ready = ctxt_mode[0];
    end
    if (pyld_mode == RDY_RAND) begin
      take_bits(1, v);
      i_pyld_ready = v[0];
    end else begin
      i_pyld_ready = pyld_mode[0];
    end
  end

  // Outputs are settled at the falling edge and transfer on the next rise
  always @(negedge axis_chdr_clk) begin
    if (!axis_chdr_rst && o_ctxt_valid && i_ctxt_ready) begin
      if (exp_ctxt.size() == 0) begin
        $display("context beat %h came out with none expected", o_ctxt.data);
        abort_run();
      end
      check_ctxt(o_ctxt, exp_ctxt.pop_front());
      if (o_ctxt.last) ctxt_pkts++;
    end
    if (!axis_chdr_rst && o_pyld_valid && i_pyld_ready) begin
      if (exp_pyld.size() == 0) begin
        $display("payload beat %h came out with none expected", o_pyld.data);
        abort_run();
      end
      check_pyld(o_pyld, exp_pyld.pop_front());
      if (o_pyld.last) pyld_pkts++;
    end
  end

  // Violations caught by the bound input checker
  always @(negedge axis_chdr_clk) begin
    if (uut.u_parser.u_input_checks.fail_count != 0) begin
      $display("the input stream broke its valid/ready contract");
      abort_run();
    end
  end

  // Budget grows with every queued beat
  always @(posedge axis_chdr_clk) begin
    cycle_cnt++;
    if (cycle_cnt > 200 + 40 * planned_beats) begin
      $display("timeout: the DUT made no progress within %0d cycles", cycle_cnt);
      abort_run();
    end
  end

  // --------------------
  // Tests
  // --------------------
  task automatic test_single_data();
    add_packet(DATA, 0, 3, 1);
    send_queued();
    wait_drained();
  endtask

  task automatic test_ts_mdata();
    add_packet(DATA_TS, 3, 4, 2);
    send_queued();
    wait_drained();
  endtask

  // Non-data packets vanish and the DATA after them stays intact
  task automatic test_drop_types();
    add_packet(CTRL, 0, 2, 3);
    add_packet(MGMT, 0, 3, 4);
    add_packet(DATA, 1, 2, 5);
    send_queued();
    wait_drained();
  endtask

  task automatic test_prefetch();
    int c0;
    int p0;
    c0 = ctxt_pkts;
    p0 = pyld_pkts;
    set_ready_mode(RDY_HIGH, RDY_LOW);
    for (int i = 0; i < 3; i++) begin
      add_packet(DATA, 0, 2, 40 + i);
    end
    sender_done = 1'b0;
    fork
      begin
        send_queued();
        sender_done = 1'b1;
      end
    join_none
    while (ctxt_pkts < c0 + 2) @(negedge axis_chdr_clk);
    // Third context is held by the gate
    repeat (50) begin
      @(negedge axis_chdr_clk);
      check_bit(o_ctxt_valid, 1'b0, "third context valid");
    end
    set_ready_mode(RDY_HIGH, RDY_HIGH);
    while (ctxt_pkts < c0 + 3) @(negedge axis_chdr_clk);
    check_bit(pyld_pkts > p0, 1'b1, "first payload done before third context");
    while (!sender_done) @(posedge axis_chdr_clk);
    #1;
    wait_drained();
  endtask

  task automatic test_random_ready();
    logic [31:0] v;
    chdr_pkt_type_e t;
    int nm;
    int nbody;
    for (int i = 0; i < 20; i++) begin
      take_bits(1, v);
      t = v[0] ? DATA_TS : DATA;
      take_bits(2, v);
      nm = int'(v[1:0]);
      take_bits(3, v);
      nbody = int'(v[2:0]) + 1;
      add_packet(t, nm, nbody, 100 + i);
    end
    set_ready_mode(RDY_RAND, RDY_RAND);
    send_queued();
    wait_drained();
    set_ready_mode(RDY_HIGH, RDY_HIGH);
  endtask

  initial begin
    axis_chdr_rst = 1'b1;
    i_chdr        = '0;
    i_chdr_valid  = 1'b0;
    i_ctxt_ready  = 1'b1;
    i_pyld_ready  = 1'b1;
    sender_done   = 1'b0;
    repeat (5) @(posedge axis_chdr_clk);
    #1;
    axis_chdr_rst = 1'b0;

    test_single_data();
    test_ts_mdata();
    test_drop_types();
    test_prefetch();
    test_random_ready();

    if (n_errors == 0 && uut.u_parser.u_input_checks.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* compile.f */
rtl/chdr_pkg.sv
rtl/ctxt_pkg.sv
rtl/chdr_header_parser.sv
rtl/stream_fifo.sv
rtl/packet_order_gate.sv
rtl/chdr_deframer.sv
sim/chdr_deframer_assertions.sv
sim/tb_chdr_deframer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the deframer testbench with Verilator

set -u
cd "$(dirname "$0")"

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_chdr_deframer \
  -Mdir obj_dir -o tb_chdr_deframer_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/tb_chdr_deframer_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if [ $sim_status -ne 0 ]; then
  echo "result: fail (simulator exit status $sim_status)"
  exit 1
fi

if grep -qx "all tests passed" "$SIM_LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi
